//--- project.f
common/periph_pkg.sv
common/periph_bus_if.sv
hdl/periph_read_buffer.sv
hdl/periph_addr_decode.sv
gpio/gpio_regs.sv
gpio/gpio_pin_mux.sv
hdl/byte_reg_periph.sv
hdl/periph_top.sv
verification/periph_props.sv
verification/periph_tb.sv

//--- verification/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_tb;
    import periph_pkg::*;

    localparam int READY_TIMEOUT = 20;

    logic       clk;
    logic       rst_n;
    pins_t      i_ui_in;
    pins_t      o_uo_out;
    addr_t      i_addr;
    data_t      i_data;
    logic [1:0] i_data_write_n;
    logic [1:0] i_data_read_n;
    data_t      o_data_out;
    logic       o_data_ready;
    logic       i_data_read_complete;

    // Reference model of the GPIO block and the byte peripherals
    pins_t gpio_out_m;
    fsel_t fsel_m [PIN_W];
    byte_t breg_m [NUM_BYTE_PERIPHS][4];

    int checks;
    int errors;
    int tests;
    int failed_tests;
    int errors_at_start;

    periph_top dut_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .o_uo_out             (o_uo_out),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .i_data_read_complete (i_data_read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Full bank address with bit 10 low, the slot in bits 9 to 6 and the offset below
    function automatic addr_t full_addr(input int slot, input int ofs);
        full_addr = {1'b0, slot_t'(slot), offset_t'(ofs)};
    endfunction

    // Byte bank address with bit 10 high, the slot in bits 7 to 4 and the register below
    function automatic addr_t byte_addr(input int slot, input int ofs);
        byte_addr = {1'b1, 2'b00, slot_t'(slot), 4'(ofs)};
    endfunction

    function automatic pins_t model_pins();
        pins_t p;
        p = '0;
        for (int i = 0; i < PIN_W; i++) begin
            if (fsel_m[i] == 5'd1) begin
                p[i] = gpio_out_m[i];
            end else if (fsel_m[i] >= 5'd16 && fsel_m[i] < 5'd16 + NUM_BYTE_PERIPHS) begin
                p[i] = breg_m[fsel_m[i] - 16][0][i];
            end
        end
        return p;
    endfunction

    task automatic check_value(input string what, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_data_ready && cycles < READY_TIMEOUT);
        if (!o_data_ready) begin
            errors++;
            $display("Timeout: o_data_ready stayed low for %0d cycles after a read", cycles);
            $display("Test FAILED");
            $finish;
        end
    endtask

    // Leaves the read presented with the data on o_data_out
    task automatic start_read(input addr_t addr);
        int cycles;
        @(negedge clk);
        i_addr        = addr;
        i_data_read_n = 2'($urandom_range(0, 2));
        #1;
        check_value("ready before capture", data_t'(o_data_ready), data_t'(0));
        wait_ready(cycles);
        check_value("read latency", data_t'(cycles), data_t'(1));
    endtask

    task automatic finish_read();
        i_data_read_n        = ACC_NONE;
        i_data_read_complete = 1'b1;
        @(negedge clk);
        i_data_read_complete = 1'b0;
    endtask

    task automatic read_check(input addr_t addr, input data_t exp, input string what);
        start_read(addr);
        check_value(what, o_data_out, exp);
        finish_read();
    endtask

    task automatic bus_write(input addr_t addr, input data_t data);
        @(negedge clk);
        i_addr         = addr;
        i_data         = data;
        i_data_read_n  = ACC_NONE;
        i_data_write_n = 2'($urandom_range(0, 2));
        #1;
        check_value("write ready", data_t'(o_data_ready), data_t'(1));
        @(negedge clk);
        i_data_write_n = ACC_NONE;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != errors_at_start) begin
            failed_tests++;
            $display("test %s: FAIL with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: pass", name);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int    n;
        int    r;
        int    k;
        int    s;
        data_t v1;
        data_t v2;

        void'($urandom(32'h8599));
        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = ACC_NONE;
        i_data_read_n        = ACC_NONE;
        i_data_read_complete = 1'b0;
        checks               = 0;
        errors               = 0;
        tests                = 0;
        failed_tests         = 0;
        errors_at_start      = 0;
        gpio_out_m           = '0;
        for (int i = 0; i < PIN_W; i++) begin
            fsel_m[i] = fsel_t'(1);
        end
        for (int i = 0; i < NUM_BYTE_PERIPHS; i++) begin
            for (int j = 0; j < 4; j++) begin
                breg_m[i][j] = '0;
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_check(full_addr(SLOT_GPIO, GPIO_OFS_OUT), '0, "gpio out after reset");
        for (int i = 0; i < PIN_W; i++) begin
            read_check(full_addr(SLOT_GPIO, GPIO_OFS_FSEL + 4 * i), data_t'(1), "fsel after reset");
        end
        check_value("pins after reset", data_t'(o_uo_out), '0);
        end_test("reset_values");

        // k == PIN_W stands for the output register
        repeat (24) begin
            k  = $urandom_range(0, PIN_W);
            v1 = $urandom;
            if (k == PIN_W) begin
                bus_write(full_addr(SLOT_GPIO, GPIO_OFS_OUT), v1);
                gpio_out_m = v1[7:0];
                read_check(full_addr(SLOT_GPIO, GPIO_OFS_OUT), data_t'(gpio_out_m), "gpio out");
            end else begin
                bus_write(full_addr(SLOT_GPIO, GPIO_OFS_FSEL + 4 * k), v1);
                fsel_m[k] = v1[4:0];
                read_check(full_addr(SLOT_GPIO, GPIO_OFS_FSEL + 4 * k), data_t'(fsel_m[k]),
                           "fsel");
            end
            i_ui_in = pins_t'($urandom);
            read_check(full_addr(SLOT_GPIO, GPIO_OFS_IN), data_t'(i_ui_in), "gpio in");
        end
        end_test("gpio_regs");

        repeat (24) begin
            n  = $urandom_range(0, NUM_BYTE_PERIPHS - 1);
            r  = $urandom_range(0, 3);
            v1 = $urandom;
            bus_write(byte_addr(n, r), v1);
            breg_m[n][r] = v1[7:0];
            read_check(byte_addr(n, r), data_t'(breg_m[n][r]), "byte reg");
        end
        repeat (8) begin
            s = $urandom_range(NUM_BYTE_PERIPHS, NUM_SLOTS - 1);
            read_check(byte_addr(s, $urandom_range(0, 15)), '0, "empty byte slot");
            s = $urandom_range(0, NUM_SLOTS - 1);
            if (s == SLOT_GPIO) begin
                s = 0;
            end
            read_check(full_addr(s, $urandom_range(0, 63)), '0, "empty full slot");
        end
        end_test("byte_periphs");

        repeat (40) begin
            k  = $urandom_range(0, PIN_W - 1);
            n  = $urandom_range(0, NUM_BYTE_PERIPHS - 1);
            v1 = $urandom;
            case ($urandom_range(0, 4))
                0: begin
                    bus_write(full_addr(SLOT_GPIO, GPIO_OFS_OUT), v1);
                    gpio_out_m = v1[7:0];
                end
                1: begin
                    bus_write(byte_addr(n, 0), v1);
                    breg_m[n][0] = v1[7:0];
                end
                2: begin
                    bus_write(full_addr(SLOT_GPIO, GPIO_OFS_FSEL + 4 * k), v1);
                    fsel_m[k] = v1[4:0];
                end
                default: begin
                    // Mostly the populated sources 1, 16 and 17
                    s  = $urandom_range(0, NUM_BYTE_PERIPHS);
                    v1 = (s == 0) ? data_t'(1) : data_t'(15 + s);
                    bus_write(full_addr(SLOT_GPIO, GPIO_OFS_FSEL + 4 * k), v1);
                    fsel_m[k] = v1[4:0];
                end
            endcase
            check_value("output pins", data_t'(o_uo_out), data_t'(model_pins()));
        end
        end_test("pin_routing");

        v1 = $urandom;
        v2 = $urandom;
        v2[7:0] = ~v1[7:0];
        bus_write(full_addr(SLOT_GPIO, GPIO_OFS_OUT), v1);
        gpio_out_m = v1[7:0];
        start_read(full_addr(SLOT_GPIO, GPIO_OFS_OUT));
        check_value("held read", o_data_out, data_t'(v1[7:0]));
        repeat (3) begin
            @(negedge clk);
            check_value("held read", o_data_out, data_t'(v1[7:0]));
        end
        bus_write(full_addr(SLOT_GPIO, GPIO_OFS_OUT), v2);
        gpio_out_m = v2[7:0];
        check_value("held across write", o_data_out, data_t'(v1[7:0]));
        // Second read without a complete still sees the old data
        start_read(full_addr(SLOT_GPIO, GPIO_OFS_OUT));
        check_value("held across write", o_data_out, data_t'(v1[7:0]));
        i_data_read_complete = 1'b1;
        @(negedge clk);
        i_data_read_complete = 1'b0;
        check_value("held until complete", o_data_out, data_t'(v1[7:0]));
        @(negedge clk);
        check_value("reload after complete", o_data_out, data_t'(v2[7:0]));
        finish_read();
        end_test("read_hold");

        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests, failed_tests, checks, errors, dut_i.props_i.prop_failures);
        if (errors == 0 && dut_i.props_i.prop_failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/periph_props.sv
`timescale 1ns/1ps
`default_nettype none

module periph_props (
    input logic              clk,
    input logic              rst_n,
    input logic [1:0]        i_write_code,
    input logic [1:0]        i_read_code,
    input logic              i_read_complete,
    input periph_pkg::data_t i_data_out,
    input logic              i_data_ready
);
    import periph_pkg::*;

    logic write_req;
    logic read_req;
    int   prop_failures = 0;

    assign write_req = (i_write_code != ACC_NONE);
    assign read_req  = (i_read_code != ACC_NONE);

    // Writes are accepted in the cycle they are presented
    write_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
        write_req |-> i_data_ready)
        else begin
            $error("write presented without o_data_ready");
            prop_failures++;
        end

    // Ready comes out of reset low unless a write is on the bus
    reset_ready_a: assert property (@(posedge clk)
        !rst_n |=> (!i_data_ready || write_req))
        else begin
            $error("o_data_ready high after reset without a request");
            prop_failures++;
        end

    // Once a read has been captured the data holds until read complete
    hold_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (read_req && $past(read_req) && i_data_ready && !i_read_complete
         && !$past(i_read_complete)) |=> $stable(i_data_out))
        else begin
            $error("o_data_out changed while a read was held");
            prop_failures++;
        end

endmodule

bind periph_top periph_props props_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_write_code    (i_data_write_n),
    .i_read_code     (i_data_read_n),
    .i_read_complete (i_data_read_complete),
    .i_data_out      (o_data_out),
    .i_data_ready    (o_data_ready)
);

`default_nettype wire

//--- hdl/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::pins_t i_ui_in,
    output periph_pkg::pins_t o_uo_out,
    input  periph_pkg::addr_t i_addr,
    input  periph_pkg::data_t i_data,
    input  logic [1:0]        i_data_write_n,
    input  logic [1:0]        i_data_read_n,
    output periph_pkg::data_t o_data_out,
    output logic              o_data_ready,
    input  logic              i_data_read_complete
);
    import periph_pkg::*;

    logic  write_req;
    logic  read_req;
    data_t slot_data;
    logic  slot_ready;
    pins_t gpio_out;
    fsel_t fsel [PIN_W];
    pins_t byte_pins [NUM_BYTE_PERIPHS];

    periph_bus_if gpio_bus ();
    periph_bus_if byte_bus [NUM_BYTE_PERIPHS] ();

    // Any size code other than ACC_NONE is a request
    assign write_req = (i_data_write_n != ACC_NONE);
    assign read_req  = (i_data_read_n != ACC_NONE);

    periph_read_buffer read_buffer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_req      (read_req),
        .i_slot_ready    (slot_ready),
        .i_slot_data     (slot_data),
        .i_write_req     (write_req),
        .i_read_complete (i_data_read_complete),
        .o_data          (o_data_out),
        .o_ready         (o_data_ready)
    );

    periph_addr_decode addr_decode_i (
        .i_addr       (i_addr),
        .i_data       (i_data),
        .i_write      (write_req),
        .o_slot_data  (slot_data),
        .o_slot_ready (slot_ready),
        .gpio_bus     (gpio_bus),
        .byte_bus     (byte_bus)
    );

    gpio_regs gpio_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ui_in    (i_ui_in),
        .bus        (gpio_bus),
        .o_gpio_out (gpio_out),
        .o_fsel     (fsel)
    );

    for (genvar n = 0; n < NUM_BYTE_PERIPHS; n++) begin : g_byte_periph
        byte_reg_periph byte_periph_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .bus      (byte_bus[n]),
            .o_uo_out (byte_pins[n])
        );
    end

    gpio_pin_mux pin_mux_i (
        .i_fsel      (fsel),
        .i_gpio_out  (gpio_out),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

`default_nettype wire

//--- hdl/byte_reg_periph.sv
`timescale 1ns/1ps
`default_nettype none

module byte_reg_periph (
    input  logic              clk,
    input  logic              rst_n,
    periph_bus_if.periph      bus,
    output periph_pkg::pins_t o_uo_out
);
    import periph_pkg::*;

    byte_t      regs [4];
    logic [1:0] sel;

    // Offset bits 3:2 are ignored, so the four registers alias across the slot
    assign sel = bus.offset[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 4; k++) begin
                regs[k] <= '0;
            end
        end else if (bus.wr_en) begin
            regs[sel] <= bus.wdata[7:0];
        end
    end

    assign bus.rdata = DATA_W'(regs[sel]);

    // Register 0 drives the pins
    assign o_uo_out = regs[0];

endmodule

`default_nettype wire

//--- gpio/gpio_pin_mux.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_pin_mux (
    input  periph_pkg::fsel_t i_fsel [periph_pkg::PIN_W],
    input  periph_pkg::pins_t i_gpio_out,
    input  periph_pkg::pins_t i_byte_pins [periph_pkg::NUM_BYTE_PERIPHS],
    output periph_pkg::pins_t o_uo_out
);
    import periph_pkg::*;

    // Pin p takes bit p of whichever source its select names
    always_comb begin
        o_uo_out = '0;
        for (int p = 0; p < PIN_W; p++) begin
            if (i_fsel[p] == fsel_t'(SLOT_GPIO)) begin
                o_uo_out[p] = i_gpio_out[p];
            end
            for (int n = 0; n < NUM_BYTE_PERIPHS; n++) begin
                if (i_fsel[p] == {1'b1, slot_t'(n)}) begin
                    o_uo_out[p] = i_byte_pins[n][p];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- gpio/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  periph_pkg::pins_t i_ui_in,
    periph_bus_if.periph      bus,
    output periph_pkg::pins_t o_gpio_out,
    output periph_pkg::fsel_t o_fsel [periph_pkg::PIN_W]
);
    import periph_pkg::*;

    pins_t      gpio_out_r;
    fsel_t      fsel_r [PIN_W];
    offset_t    fsel_rel;
    logic       fsel_hit;
    logic [2:0] fsel_idx;
    logic       out_hit;
    logic       in_hit;

    assign out_hit = (bus.offset == offset_t'(GPIO_OFS_OUT));
    assign in_hit  = (bus.offset == offset_t'(GPIO_OFS_IN));

    // Function selects are word aligned from GPIO_OFS_FSEL up
    assign fsel_rel = bus.offset - offset_t'(GPIO_OFS_FSEL);
    assign fsel_hit = (bus.offset >= offset_t'(GPIO_OFS_FSEL)) && (fsel_rel[1:0] == 2'b00);
    assign fsel_idx = fsel_rel[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_r <= '0;
        end else if (bus.wr_en && out_hit) begin
            gpio_out_r <= bus.wdata[PIN_W-1:0];
        end
    end

    // All pins start on the GPIO output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < PIN_W; k++) begin
                fsel_r[k] <= fsel_t'(SLOT_GPIO);
            end
        end else if (bus.wr_en && fsel_hit) begin
            fsel_r[fsel_idx] <= bus.wdata[4:0];
        end
    end

    always_comb begin
        if (out_hit) begin
            bus.rdata = DATA_W'(gpio_out_r);
        end else if (in_hit) begin
            bus.rdata = DATA_W'(i_ui_in);
        end else if (fsel_hit) begin
            bus.rdata = DATA_W'(fsel_r[fsel_idx]);
        end else begin
            bus.rdata = '0;
        end
    end

    assign o_gpio_out = gpio_out_r;
    assign o_fsel     = fsel_r;

endmodule

`default_nettype wire

//--- hdl/periph_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module periph_addr_decode (
    input  periph_pkg::addr_t i_addr,
    input  periph_pkg::data_t i_data,
    input  logic              i_write,
    output periph_pkg::data_t o_slot_data,
    output logic              o_slot_ready,
    periph_bus_if.decoder     gpio_bus,
    periph_bus_if.decoder     byte_bus [periph_pkg::NUM_BYTE_PERIPHS]
);
    import periph_pkg::*;

    logic  byte_bank;
    slot_t full_slot;
    slot_t byte_slot;
    data_t full_rdata [NUM_SLOTS];
    byte_t byte_rdata [NUM_SLOTS];

    // Top address bit selects the byte bank
    assign byte_bank = i_addr[ADDR_W-1];
    assign full_slot = i_addr[9:6];
    assign byte_slot = i_addr[7:4];

    assign gpio_bus.offset = i_addr[5:0];
    assign gpio_bus.wdata  = i_data;
    assign gpio_bus.wr_en  = i_write && !byte_bank && (full_slot == slot_t'(SLOT_GPIO));

    // Unpopulated full slots return zero
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_full
        if (s == SLOT_GPIO) begin : g_gpio
            assign full_rdata[s] = gpio_bus.rdata;
        end else begin : g_empty
            assign full_rdata[s] = '0;
        end
    end

    // Byte peripherals fill the bank from slot 0 upward
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_byte
        if (s < NUM_BYTE_PERIPHS) begin : g_periph
            assign byte_bus[s].offset = i_addr[5:0];
            assign byte_bus[s].wdata  = i_data;
            assign byte_bus[s].wr_en  = i_write && byte_bank && (byte_slot == slot_t'(s));
            assign byte_rdata[s]      = byte_bus[s].rdata[7:0];
        end else begin : g_empty
            assign byte_rdata[s] = '0;
        end
    end

    always_comb begin
        if (byte_bank) begin
            o_slot_data = DATA_W'(byte_rdata[byte_slot]);
        end else begin
            o_slot_data = full_rdata[full_slot];
        end
    end

    // Every slot including the empty ones answers at once so no read can stall
    assign o_slot_ready = 1'b1;

endmodule

`default_nettype wire

//--- hdl/periph_read_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module periph_read_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_read_req,
    input  logic              i_slot_ready,
    input  periph_pkg::data_t i_slot_data,
    input  logic              i_write_req,
    input  logic              i_read_complete,
    output periph_pkg::data_t o_data,
    output logic              o_ready
);
    import periph_pkg::*;

    logic  hold;
    logic  ready_r;
    logic  load;
    data_t data_r;

    // Capture once per read so the core sees frozen data until it completes
    assign load = i_read_req && i_slot_ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (load) begin
                hold <= 1'b1;
            end
            // Registered to line up with the registered data
            ready_r <= i_read_req && i_slot_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_r <= i_slot_data;
        end
    end

    assign o_data = data_r;

    // Writes complete in the cycle they are presented
    assign o_ready = ready_r || i_write_req;

endmodule

`default_nettype wire

//--- common/periph_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
    import periph_pkg::*;

    // Offset inside the slot of which byte peripherals only use the low four bits
    offset_t offset;
    data_t   wdata;

    // High only while this slot is selected and a write is presented
    logic    wr_en;

    // Combinational read data from the peripheral
    data_t   rdata;

    modport decoder (
        output offset,
        output wdata,
        output wr_en,
        input  rdata
    );

    modport periph (
        input  offset,
        input  wdata,
        input  wr_en,
        output rdata
    );

endinterface

`default_nettype wire

//--- common/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // Bus and pin widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int PIN_W  = 8;

    // Slots in each of the full and byte banks
    localparam int NUM_SLOTS        = 16;
    localparam int NUM_BYTE_PERIPHS = 2;

    // Full slot that holds the GPIO block
    localparam int SLOT_GPIO = 1;

    // GPIO register offsets within its slot
    localparam int GPIO_OFS_OUT  = 0;
    localparam int GPIO_OFS_IN   = 4;
    // Function select k lives at GPIO_OFS_FSEL + 4*k
    localparam int GPIO_OFS_FSEL = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [7:0]        byte_t;
    typedef logic [PIN_W-1:0]  pins_t;
    typedef logic [5:0]        offset_t;
    typedef logic [3:0]        slot_t;

    // Top bit picks the byte bank and the low four bits pick the slot
    typedef logic [4:0]        fsel_t;

    // Size code on the core bus where ACC_NONE means no request
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_e;

endpackage

`default_nettype wire
